/* hw/tcdm_pkg.sv */
// tcdm shared definitions
// width constants and the request/response payload structs for the core port

package tcdm_pkg;

  // byte address and data word sizes
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8; // one enable per byte lane
  localparam int unsigned IdWidth   = 4;

  // core request payload, 73 bits
  // field order is fixed since testbench and banks share the layout
  typedef struct packed {
    logic [AddrWidth-1:0] addr;  // byte address, low two bits ignored
    logic [DataWidth-1:0] wdata; // write data, don't care on reads
    logic [BeWidth-1:0]   be;    // byte enables for writes
    logic                 we;    // 1 = write, 0 = read
    logic [IdWidth-1:0]   id;    // echoed back with read data
  } tcdm_req_t;

  // read response payload, 36 bits
  typedef struct packed {
    logic [DataWidth-1:0] rdata; // word read from the bank
    logic [IdWidth-1:0]   id;    // id of the read that produced it
  } tcdm_rsp_t;

endpackage

/* hw/tcdm_sram.sv */
// behavioral single-port sram for one tcdm bank
// byte-lane writes, registered read data, contents start as all ones

`timescale 1ns/1ps

module tcdm_sram #(
  parameter int unsigned BankWords = 64
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [$clog2(BankWords)-1:0]       addr_i,
  input  logic [tcdm_pkg::DataWidth-1:0]     wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]       be_i,
  output logic [tcdm_pkg::DataWidth-1:0]     rdata_o
);

  logic [tcdm_pkg::DataWidth-1:0] mem_q [BankWords];
  logic [tcdm_pkg::DataWidth-1:0] rdata_q; // holds last read word

  // power-up contents, same as the "ones" init of the real macro
  initial begin
    for (int w = 0; w < BankWords; w++) begin
      mem_q[w] = '1;
    end
  end

  // write path, one byte lane at a time
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read path, word sampled on the request edge
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i]; // previous value kept when idle
    end
  end

  assign rdata_o = rdata_q;

  // a write with no lanes enabled points at a broken master
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && we_i) |-> (be_i != '0))
    else $error("tcdm_sram: write with all byte enables low");

endmodule

/* hw/tcdm_bank.sv */
// one tcdm bank
// wraps the sram, throttles its grant with an lfsr, echoes the read id
// and flags read data one cycle after the grant

`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned BankWords     = 64,
  parameter logic [15:0] GrantThrottle = 16'hace1 // nonzero lfsr seed
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_en_i,
  input  logic                  req_i,
  input  tcdm_pkg::tcdm_req_t   req_data_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output tcdm_pkg::tcdm_rsp_t   rsp_o
);

  localparam int unsigned WordBits = $clog2(BankWords);

  logic [15:0]                      lfsr_q;
  logic                             lfsr_fb;
  logic                             gnt_q;
  logic                             rvalid_q;
  logic [tcdm_pkg::IdWidth-1:0]     id_q;
  logic                             xfer;    // req and gnt this cycle
  logic                             rd_gnt;  // granted read
  logic [WordBits-1:0]              word_idx;
  logic [tcdm_pkg::DataWidth-1:0]   sram_rdata;

  // 16-bit fibonacci lfsr with taps 16,14,13,11
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= GrantThrottle;
      gnt_q  <= 1'b1; // banks come out of reset ready
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      // roughly 3 of 4 cycles granted when throttling
      gnt_q  <= stall_en_i ? (lfsr_q[0] | lfsr_q[3]) : 1'b1;
    end
  end

  assign gnt_o  = gnt_q;
  assign xfer   = req_i && gnt_q;
  assign rd_gnt = xfer && !req_data_i.we;

  // router already stripped the bank bits so the word index sits at bit 2
  assign word_idx = req_data_i.addr[2 +: WordBits];

  tcdm_sram #(
    .BankWords (BankWords)
  ) tcdm_sram_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (xfer),
    .we_i    (req_data_i.we),
    .addr_i  (word_idx),
    .wdata_i (req_data_i.wdata),
    .be_i    (req_data_i.be),
    .rdata_o (sram_rdata)
  );

  // read valid is high for exactly the cycle after a granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_gnt;
    end
  end

  // id rides along with the read
  always_ff @(posedge clk_i) begin
    if (rd_gnt) begin
      id_q <= req_data_i.id;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rsp_o.rdata = sram_rdata;
  assign rsp_o.id    = id_q;

endmodule

/* hw/tcdm_req_router.sv */
// request router for the single core port
// picks the target bank from the address, forwards req/gnt and
// withholds reads while the response path has no room

`timescale 1ns/1ps

module tcdm_req_router #(
  parameter int unsigned NbBanks = 4 // power of two, at least 2
) (
  input  logic                  core_req_i,
  input  tcdm_pkg::tcdm_req_t   core_req_data_i,
  output logic                  core_gnt_o,
  output logic [NbBanks-1:0]    bank_req_o,
  output tcdm_pkg::tcdm_req_t   bank_req_data_o,
  input  logic [NbBanks-1:0]    bank_gnt_i,
  input  logic                  rsp_room_i,
  output logic                  rd_issue_o
);

  localparam int unsigned BankBits = $clog2(NbBanks);

  logic [BankBits-1:0] bank_idx;
  logic                may_go;  // write, or read with a free response slot
  logic                fwd;     // request forwarded to the bank

  // word-interleaved so the bank bits sit right above the byte offset
  assign bank_idx = core_req_data_i.addr[2 +: BankBits];

  assign may_go = core_req_data_i.we || rsp_room_i;
  assign fwd    = core_req_i && may_go;

  // one-hot request towards the decoded bank only
  assign bank_req_o = fwd ? (NbBanks'(1) << bank_idx) : '0;

  // broadcast payload with bank bits squeezed out of the address
  // so every bank finds its word index at bit 2
  always_comb begin
    bank_req_data_o      = core_req_data_i;
    bank_req_data_o.addr = (core_req_data_i.addr >> (BankBits + 2)) << 2;
  end

  // grant follows the bank and reads also need response room
  assign core_gnt_o = bank_gnt_i[bank_idx] && may_go;

  // tells the merger a response is coming next cycle
  assign rd_issue_o = core_req_i && core_gnt_o && !core_req_data_i.we;

endmodule

/* hw/tcdm_resp_merge.sv */
// response merger
// funnels the bank responses into one ordered stream through a
// two-entry fall-through buffer and reports room for new reads

`timescale 1ns/1ps

module tcdm_resp_merge #(
  parameter int unsigned NbBanks = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rd_issue_i,
  input  logic [NbBanks-1:0]    bank_rvalid_i,
  input  tcdm_pkg::tcdm_rsp_t   bank_rsp_i [NbBanks],
  output logic                  rsp_room_o,
  output logic                  core_rvalid_o,
  output tcdm_pkg::tcdm_rsp_t   core_rsp_o,
  input  logic                  core_rready_i
);

  tcdm_pkg::tcdm_rsp_t fifo_q [2]; // two response slots
  tcdm_pkg::tcdm_rsp_t in_rsp;
  logic                in_valid;
  logic                wr_ptr_q, rd_ptr_q;
  logic [1:0]          cnt_q;
  logic                inflight_q; // read granted last cycle whose data arrives now
  logic [1:0]          occ;
  logic                push, pop, empty;

  // at most one bank answers per cycle
  always_comb begin
    in_rsp = '0;
    for (int b = 0; b < NbBanks; b++) begin
      if (bank_rvalid_i[b]) in_rsp = bank_rsp_i[b];
    end
  end
  assign in_valid = |bank_rvalid_i;

  assign empty = (cnt_q == 2'd0);
  assign pop   = !empty && core_rready_i;
  assign push  = in_valid && !(empty && core_rready_i); // bypass when empty and ready

  // head of buffer wins over the straight-through path
  assign core_rvalid_o = !empty || in_valid;
  assign core_rsp_o    = empty ? in_rsp : fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) fifo_q[wr_ptr_q] <= in_rsp;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
      cnt_q      <= 2'd0;
      inflight_q <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      cnt_q      <= cnt_q + 2'(push) - 2'(pop);
      inflight_q <= rd_issue_i;
    end
  end

  // entries plus the response on its way where two means full
  assign occ        = cnt_q + 2'(inflight_q);
  assign rsp_room_o = (occ < 2'd2);

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_rvalid_i))
    else $error("tcdm_resp_merge: several banks answered at once");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push && !pop) |-> (cnt_q != 2'd2))
    else $error("tcdm_resp_merge: response buffer overflow");

endmodule

/* hw/tcdm_banks_top.sv */
// word-interleaved tcdm behind one core port
// router in front, NbBanks sram banks, ordered response merger behind

`timescale 1ns/1ps

module tcdm_banks_top #(
  parameter int unsigned NbBanks   = 4,  // power of two
  parameter int unsigned BankWords = 64  // words per bank
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_en_i,    // enables random grant throttling
  input  logic                  core_req_i,
  input  tcdm_pkg::tcdm_req_t   core_req_data_i,
  output logic                  core_gnt_o,
  output logic                  core_rvalid_o,
  output tcdm_pkg::tcdm_rsp_t   core_rsp_o,
  input  logic                  core_rready_i
);

  logic [NbBanks-1:0]    bank_req;
  tcdm_pkg::tcdm_req_t   bank_req_data; // same payload to every bank
  logic [NbBanks-1:0]    bank_gnt;
  logic [NbBanks-1:0]    bank_rvalid;
  tcdm_pkg::tcdm_rsp_t   bank_rsp [NbBanks];
  logic                  rsp_room;
  logic                  rd_issue;

  tcdm_req_router #(
    .NbBanks (NbBanks)
  ) tcdm_req_router_inst (
    .core_req_i      (core_req_i),
    .core_req_data_i (core_req_data_i),
    .core_gnt_o      (core_gnt_o),
    .bank_req_o      (bank_req),
    .bank_req_data_o (bank_req_data),
    .bank_gnt_i      (bank_gnt),
    .rsp_room_i      (rsp_room),
    .rd_issue_o      (rd_issue)
  );

  for (genvar i = 0; i < NbBanks; i++) begin : gen_banks
    // distinct seed per bank, bit 0 forced so the lfsr never locks at zero
    tcdm_bank #(
      .BankWords     (BankWords),
      .GrantThrottle (16'(16'hace1 + i * 16'h1f35) | 16'h0001)
    ) tcdm_bank_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .stall_en_i (stall_en_i),
      .req_i      (bank_req[i]),
      .req_data_i (bank_req_data),
      .gnt_o      (bank_gnt[i]),
      .rvalid_o   (bank_rvalid[i]),
      .rsp_o      (bank_rsp[i])
    );
  end

  tcdm_resp_merge #(
    .NbBanks (NbBanks)
  ) tcdm_resp_merge_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_issue_i    (rd_issue),
    .bank_rvalid_i (bank_rvalid),
    .bank_rsp_i    (bank_rsp),
    .rsp_room_o    (rsp_room),
    .core_rvalid_o (core_rvalid_o),
    .core_rsp_o    (core_rsp_o),
    .core_rready_i (core_rready_i)
  );

endmodule

/* testbench/tb_tcdm_vectors.svh */
// stimulus table for the tcdm testbench
// one row per core request, applied in order

`ifndef TB_TCDM_VECTORS_SVH
`define TB_TCDM_VECTORS_SVH

// columns: we, addr, be, wdata, id, stall_en, rready_gap, chk, exp_rdata
// chk = 1 means exp_rdata is fixed by rule, chk = 0 leaves it to the reference model
typedef struct packed {
  logic        we;         // 1 = write
  logic [31:0] addr;
  logic [3:0]  be;
  logic [31:0] wdata;
  logic [3:0]  id;
  logic        stall_en;   // grant throttling on
  logic [2:0]  rready_gap; // max cycles of rready low per drop
  logic        chk;
  logic [31:0] exp_rdata;
} vec_row_t;

localparam int NumRows = 36;

vec_row_t vectors [NumRows] = '{
  // unwritten words read back as all ones
  '{1'b0, 32'h0000_0000, 4'hf, 32'h0000_0000, 4'h1, 1'b0, 3'd0, 1'b1, 32'hffff_ffff},
  '{1'b0, 32'h0000_00f4, 4'hf, 32'h0000_0000, 4'h2, 1'b0, 3'd0, 1'b1, 32'hffff_ffff},
  '{1'b0, 32'h0000_03fc, 4'hf, 32'h0000_0000, 4'h3, 1'b0, 3'd0, 1'b1, 32'hffff_ffff},
  // consecutive words, one per bank
  '{1'b1, 32'h0000_0010, 4'hf, 32'h1111_1111, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b1, 32'h0000_0014, 4'hf, 32'h2222_2222, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b1, 32'h0000_0018, 4'hf, 32'h3333_3333, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b1, 32'h0000_001c, 4'hf, 32'h4444_4444, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0010, 4'hf, 32'h0000_0000, 4'h4, 1'b0, 3'd0, 1'b1, 32'h1111_1111},
  '{1'b0, 32'h0000_0014, 4'hf, 32'h0000_0000, 4'h5, 1'b0, 3'd0, 1'b1, 32'h2222_2222},
  '{1'b0, 32'h0000_0018, 4'hf, 32'h0000_0000, 4'h6, 1'b0, 3'd0, 1'b1, 32'h3333_3333},
  '{1'b0, 32'h0000_001c, 4'hf, 32'h0000_0000, 4'h7, 1'b0, 3'd0, 1'b1, 32'h4444_4444},
  // aliases, differ only above bit 9
  '{1'b0, 32'h0000_0410, 4'hf, 32'h0000_0000, 4'h8, 1'b0, 3'd0, 1'b1, 32'h1111_1111},
  '{1'b0, 32'habc0_0018, 4'hf, 32'h0000_0000, 4'h9, 1'b0, 3'd0, 1'b1, 32'h3333_3333},
  // partial writes merged lane by lane, read right after each write
  '{1'b1, 32'h0000_0020, 4'h1, 32'hdead_be5a, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0020, 4'hf, 32'h0000_0000, 4'ha, 1'b0, 3'd0, 1'b1, 32'hffff_ff5a},
  '{1'b1, 32'h0000_0020, 4'hc, 32'h1234_0000, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0020, 4'hf, 32'h0000_0000, 4'hb, 1'b0, 3'd0, 1'b1, 32'h1234_ff5a},
  '{1'b1, 32'h0000_0420, 4'h2, 32'h0000_c300, 4'h0, 1'b0, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0020, 4'hf, 32'h0000_0000, 4'hc, 1'b0, 3'd0, 1'b1, 32'h1234_c35a},
  // back-pressure, expected data from the reference model
  '{1'b0, 32'h0000_0010, 4'hf, 32'h0000_0000, 4'hd, 1'b0, 3'd3, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0014, 4'hf, 32'h0000_0000, 4'he, 1'b0, 3'd3, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0020, 4'hf, 32'h0000_0000, 4'hf, 1'b0, 3'd3, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_001c, 4'hf, 32'h0000_0000, 4'h0, 1'b0, 3'd2, 1'b0, 32'h0000_0000},
  '{1'b1, 32'h0000_0014, 4'hf, 32'h55aa_55aa, 4'h0, 1'b0, 3'd2, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0014, 4'hf, 32'h0000_0000, 4'h1, 1'b0, 3'd2, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_00f4, 4'hf, 32'h0000_0000, 4'h2, 1'b0, 3'd3, 1'b0, 32'h0000_0000},
  // throttled grants, then the same reads unthrottled
  '{1'b1, 32'h0000_0030, 4'hf, 32'hcafe_f00d, 4'h0, 1'b1, 3'd0, 1'b0, 32'h0000_0000},
  '{1'b0, 32'h0000_0030, 4'hf, 32'h0000_0000, 4'h3, 1'b1, 3'd0, 1'b1, 32'hcafe_f00d},
  '{1'b0, 32'h0000_0010, 4'hf, 32'h0000_0000, 4'h4, 1'b1, 3'd0, 1'b1, 32'h1111_1111},
  '{1'b0, 32'h0000_0014, 4'hf, 32'h0000_0000, 4'h5, 1'b1, 3'd0, 1'b1, 32'h55aa_55aa},
  '{1'b0, 32'h0000_0020, 4'hf, 32'h0000_0000, 4'h6, 1'b1, 3'd0, 1'b1, 32'h1234_c35a},
  '{1'b0, 32'h0000_03fc, 4'hf, 32'h0000_0000, 4'h7, 1'b1, 3'd2, 1'b1, 32'hffff_ffff},
  '{1'b0, 32'h0000_0018, 4'hf, 32'h0000_0000, 4'h8, 1'b1, 3'd3, 1'b1, 32'h3333_3333},
  '{1'b0, 32'h0000_0030, 4'hf, 32'h0000_0000, 4'h9, 1'b0, 3'd0, 1'b1, 32'hcafe_f00d},
  '{1'b0, 32'h0000_0010, 4'hf, 32'h0000_0000, 4'ha, 1'b0, 3'd0, 1'b1, 32'h1111_1111},
  '{1'b0, 32'h0000_0014, 4'hf, 32'h0000_0000, 4'hb, 1'b0, 3'd0, 1'b1, 32'h55aa_55aa}
};

`endif

/* testbench/tb_tcdm_banks.sv */
// testbench for the word-interleaved tcdm
// table-driven core requests, reference memory, ordered response checks

`timescale 1ns/1ps

module tb_tcdm_banks;

  localparam int unsigned NbBanks   = 4;
  localparam int unsigned BankWords = 64;
  localparam int unsigned IdxBits   = $clog2(NbBanks) + $clog2(BankWords); // bank plus word

  `include "tb_tcdm_vectors.svh"

  localparam int TimeoutCycles = NumRows * 12 + 100;

  logic                clk_i;
  logic                rst_ni;
  logic                stall_en_i;
  logic                core_req_i;
  tcdm_pkg::tcdm_req_t core_req_data_i;
  logic                core_gnt_o;
  logic                core_rvalid_o;
  tcdm_pkg::tcdm_rsp_t core_rsp_o;
  logic                core_rready_i;

  logic [31:0]         ref_mem [NbBanks*BankWords]; // flat word view of all banks
  tcdm_pkg::tcdm_rsp_t exp_q [$];                   // reads in grant order
  tcdm_pkg::tcdm_rsp_t held_rsp;
  tcdm_pkg::tcdm_rsp_t head;
  logic                held;     // response shown last cycle, not taken yet
  logic                granted;
  int                  mismatch_cnt;
  int                  other_cnt;
  int                  cycle_cnt;
  int                  cur_gap;  // rready gap of the row on the bus
  int                  hold_cnt; // cycles of rready low still to go
  integer              seed;

  tcdm_banks_top #(
    .NbBanks   (NbBanks),
    .BankWords (BankWords)
  ) tcdm_banks_top_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_en_i      (stall_en_i),
    .core_req_i      (core_req_i),
    .core_req_data_i (core_req_data_i),
    .core_gnt_o      (core_gnt_o),
    .core_rvalid_o   (core_rvalid_o),
    .core_rsp_o      (core_rsp_o),
    .core_rready_i   (core_rready_i)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i; // 4 ns period

  // put one table row on the core port
  task automatic drive_row(input int r);
    core_req_i            = 1'b1;
    core_req_data_i.addr  = vectors[r].addr;
    core_req_data_i.wdata = vectors[r].wdata;
    core_req_data_i.be    = vectors[r].be;
    core_req_data_i.we    = vectors[r].we;
    core_req_data_i.id    = vectors[r].id;
    stall_en_i            = vectors[r].stall_en;
    cur_gap               = int'(vectors[r].rready_gap);
  endtask

  // granted write updates the model and granted read queues its response
  task automatic note_grant(input int r);
    logic [IdxBits-1:0]  idx;
    tcdm_pkg::tcdm_rsp_t exp_rsp;
    idx = vectors[r].addr[2 +: IdxBits]; // aliases fold onto the same word
    if (vectors[r].we) begin
      for (int b = 0; b < 4; b++) begin
        if (vectors[r].be[b]) begin
          ref_mem[idx][b*8 +: 8] = vectors[r].wdata[b*8 +: 8];
        end
      end
    end else begin
      exp_rsp.rdata = vectors[r].chk ? vectors[r].exp_rdata : ref_mem[idx];
      exp_rsp.id    = vectors[r].id;
      exp_q.push_back(exp_rsp);
    end
  endtask

  // compare an accepted response with the oldest outstanding read
  task automatic check_response();
    assert (exp_q.size() != 0) else begin
      $display("t=%0t response with id %h arrived while no read was outstanding",
               $time, core_rsp_o.id);
      other_cnt++;
    end
    if (exp_q.size() != 0) begin
      head = exp_q.pop_front();
      assert (core_rsp_o.rdata == head.rdata) else begin
        $display("MISMATCH t=%0t core_rsp_o.rdata got %h expected %h",
                 $time, core_rsp_o.rdata, head.rdata);
        mismatch_cnt++;
      end
      assert (core_rsp_o.id == head.id) else begin
        $display("MISMATCH t=%0t core_rsp_o.id got %h expected %h",
                 $time, core_rsp_o.id, head.id);
        mismatch_cnt++;
      end
    end
  endtask

  // response side sampled mid-cycle once everything has settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      held = 1'b0;
    end else begin
      if (held) begin
        assert (core_rvalid_o && core_rsp_o == held_rsp) else begin
          $display("t=%0t pending response %h changed or vanished before it was accepted",
                   $time, held_rsp);
          other_cnt++;
        end
      end
      if (core_rvalid_o && core_rready_i) begin
        check_response();
        held = 1'b0;
      end else begin
        held     = core_rvalid_o;
        held_rsp = core_rsp_o;
      end
    end
  end

  // random rready drops of at most cur_gap cycles each
  always @(posedge clk_i) begin
    int   gap;    // gap of the row on the bus at this edge
    logic in_rst;
    gap    = cur_gap;
    in_rst = !rst_ni;
    #1;
    if (in_rst || gap == 0) begin
      core_rready_i = 1'b1;
      hold_cnt      = 0;
    end else if (hold_cnt != 0) begin
      core_rready_i = 1'b0;
      hold_cnt--;
    end else if (($random(seed) & 3) == 0) begin
      core_rready_i = 1'b0; // one in four cycles starts a drop
      hold_cnt      = ($unsigned($random(seed)) % gap);
    end else begin
      core_rready_i = 1'b1;
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout after %0d cycles, %0d reads still outstanding",
               cycle_cnt, exp_q.size());
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    rst_ni          = 1'b0;
    stall_en_i      = 1'b0;
    core_req_i      = 1'b0;
    core_req_data_i = '0;
    core_rready_i   = 1'b1;
    seed            = 32'hee76;
    mismatch_cnt    = 0;
    other_cnt       = 0;
    cycle_cnt       = 0;
    cur_gap         = 0;
    hold_cnt        = 0;
    held            = 1'b0;
    for (int w = 0; w < NbBanks * BankWords; w++) begin
      ref_mem[w] = '1; // banks power up as all ones
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // each row held until granted and the next row follows right away
    for (int r = 0; r < NumRows; r++) begin
      drive_row(r);
      granted = 1'b0;
      while (!granted) begin
        @(negedge clk_i);
        granted = core_req_i && core_gnt_o;
        if (granted) begin
          note_grant(r);
        end
        @(posedge clk_i);
        #1;
      end
    end
    core_req_i = 1'b0;
    cur_gap    = 0;

    // drain outstanding reads and then idle a few cycles to catch strays
    for (int c = 0; c < 50 && exp_q.size() != 0; c++) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    assert (exp_q.size() == 0) else begin
      $display("%0d expected read responses never came back", exp_q.size());
      other_cnt++;
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+testbench
hw/tcdm_pkg.sv
hw/tcdm_sram.sv
hw/tcdm_bank.sv
hw/tcdm_req_router.sv
hw/tcdm_resp_merge.sv
hw/tcdm_banks_top.sv
testbench/tb_tcdm_banks.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tcdm testbench with verilator
# exit status follows the pass message in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f \
  --top-module tb_tcdm_banks -o tb_tcdm_banks \
  && ./obj_dir/tb_tcdm_banks > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }

cat sim.log
grep -q "^Testbench passed$" sim.log && exit 0 || exit 1
